/* project.f */
+incdir+include
verilog/mpeg_stream_pkg.sv
verilog/scramble_pkg.sv
verilog/byte_fifo.sv
verilog/packet_splitter.sv
verilog/sign_scrambler.sv
verilog/stream_joiner.sv
verilog/bhargava_top.sv
dv/bhargava_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module bhargava_tb \
		-f project.f -o bhargava_sim
	./obj_dir/bhargava_sim | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/bhargava_tb.sv */
`include "bhargava_settings.svh"

module bhargava_tb;

	localparam int PKT_LEN = `BHG_PKT_LEN;
	localparam int WAIT_LIMIT = 400;
	localparam int DRAIN_LIMIT = 4000;

	logic       clk;
	logic       rst_n;
	logic [7:0] mpeg_in;
	logic       mpeg_in_en;
	logic [7:0] mpeg_out;
	logic       mpeg_out_en;
	logic       mpeg_prog_full;

	logic [31:0] rng_state;
	logic [7:0]  exp_q[$];
	string       test_name;
	int          err_cnt;

	// reference model of the packet and keystream rules
	int          model_pos;
	logic        model_video;
	logic [15:0] model_key;

	bhargava_top bhargava_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.mpeg_in(mpeg_in),
		.mpeg_in_en(mpeg_in_en),
		.mpeg_out(mpeg_out),
		.mpeg_out_en(mpeg_out_en),
		.mpeg_prog_full(mpeg_prog_full)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic int random_gap(input int max_gap);
		if (max_gap == 0)
			return 0;
		return int'(next_rand() % 32'(max_gap + 1));
	endfunction

	task automatic fail_now();
		err_cnt++;
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
			fail_now();
		end
	endtask

	task automatic model_push(input logic [7:0] b);
		logic [7:0] e;
		e = b;
		if (model_pos == 0) begin
			model_video = (b == `BHG_VIDEO_ID);
			if (model_video)
				model_key = `BHG_KEY_SEED;
		end else if (model_video) begin
			e[7] = b[7] ^ model_key[15];
			model_key = {model_key[14:0],
				model_key[15] ^ model_key[13] ^ model_key[12] ^ model_key[10]};
		end
		exp_q.push_back(e);
		model_pos = (model_pos + 1) % PKT_LEN;
	endtask

	// inputs change 1 unit after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic idle(input int cycles);
		mpeg_in_en = 1'b0;
		repeat (cycles) step();
	endtask

	task automatic write_byte(input logic [7:0] b);
		int n;
		n = 0;
		while (mpeg_prog_full) begin
			if (n >= WAIT_LIMIT) begin
				$display("timeout: mpeg_prog_full stayed high while waiting to write");
				fail_now();
			end
			mpeg_in_en = 1'b0;
			step();
			n++;
		end
		mpeg_in = b;
		mpeg_in_en = 1'b1;
		model_push(b);
		step();
	endtask

	task automatic send_packet(input logic video, input int max_gap);
		logic [7:0] hdr;
		int i;
		hdr = video ? `BHG_VIDEO_ID : 8'(next_rand() >> 8);
		if (!video && hdr == `BHG_VIDEO_ID)
			hdr = ~hdr;
		write_byte(hdr);
		idle(random_gap(max_gap));
		for (i = 1; i < PKT_LEN; i++) begin
			write_byte(8'(next_rand() >> 16));
			idle(random_gap(max_gap));
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		mpeg_in_en = 1'b0;
		while (exp_q.size() != 0) begin
			if (n >= DRAIN_LIMIT) begin
				$display("timeout: output did not drain, %0d bytes still expected",
					exp_q.size());
				fail_now();
			end
			step();
			n++;
		end
		// quiet window catches stray extra bytes
		idle(10);
	endtask

	task automatic apply_reset(input int cycles);
		mpeg_in_en = 1'b0;
		rst_n = 1'b0;
		step();
		// everything in flight is gone after the first reset edge
		exp_q.delete();
		model_pos = 0;
		model_video = 1'b0;
		model_key = `BHG_KEY_SEED;
		repeat (cycles - 1) step();
		rst_n = 1'b1;
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		logic [7:0] head;
		if (mpeg_out_en === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("output byte %0h appeared with no byte expected", mpeg_out);
				fail_now();
			end else begin
				head = exp_q.pop_front();
				check_value(test_name, 32'(head), 32'(mpeg_out));
			end
		end
	end

	initial begin
		int k;
		rst_n = 1'b0;
		mpeg_in = 8'h00;
		mpeg_in_en = 1'b0;
		rng_state = 32'h41bb_1ced;
		err_cnt = 0;
		test_name = "reset";

		apply_reset(3);
		check_value("reset_out_en", 32'(0), 32'(mpeg_out_en));
		check_value("reset_prog_full", 32'(0), 32'(mpeg_prog_full));
		step();

		test_name = "misc_packets";
		for (k = 0; k < 4; k++)
			send_packet(1'b0, 2);
		wait_drain();

		test_name = "video_packets";
		send_packet(1'b1, 1);
		send_packet(1'b0, 1);
		send_packet(1'b1, 0);
		send_packet(1'b1, 2);
		wait_drain();

		test_name = "random_mix";
		for (k = 0; k < 40; k++)
			send_packet(next_rand() % 2 == 0, 3);
		wait_drain();

		test_name = "back_pressure";
		for (k = 0; k < 24; k++)
			send_packet(next_rand() % 3 != 0, 0);
		wait_drain();
		check_value("back_pressure_prog_full", 32'(0), 32'(mpeg_prog_full));

		test_name = "reset_mid_packet";
		write_byte(`BHG_VIDEO_ID);
		for (k = 0; k < 3; k++)
			write_byte(8'(next_rand()));
		apply_reset(3);
		check_value("mid_reset_out_en", 32'(0), 32'(mpeg_out_en));
		send_packet(1'b1, 1);
		send_packet(1'b0, 1);
		send_packet(1'b1, 0);
		wait_drain();

		if (err_cnt == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			fail_now();
		end
	end

endmodule

/* verilog/bhargava_top.sv */
`include "bhargava_settings.svh"

module bhargava_top (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] mpeg_in,
	input  logic       mpeg_in_en,
	output logic [7:0] mpeg_out,
	output logic       mpeg_out_en,
	output logic       mpeg_prog_full
);

	localparam int IN_CW = $clog2(`BHG_IN_DEPTH + 1);

	logic [7:0]                   in_dout;
	logic                         in_empty;
	logic [IN_CW-1:0]             in_count;
	logic                         rd;
	logic [7:0]                   vid_byte;
	mpeg_stream_pkg::byte_class_t vid_class;
	logic                         vid_valid;
	logic [7:0]                   misc_byte;
	logic                         misc_valid;
	mpeg_stream_pkg::byte_class_t order_class;
	logic                         order_valid;
	logic [7:0]                   scr_byte;
	logic                         scr_valid;
	logic                         join_afull;

	byte_fifo #(
		.WIDTH(8),
		.DEPTH(`BHG_IN_DEPTH),
		.PROG_LEVEL(`BHG_IN_PROG_FULL)
	) in_fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.din(mpeg_in),
		.wr(mpeg_in_en),
		.rd(rd),
		.dout(in_dout),
		.empty(in_empty),
		.count(in_count),
		.prog_full(mpeg_prog_full)
	);

	packet_splitter splitter_i (
		.clk(clk),
		.rst_n(rst_n),
		.dout(in_dout),
		.empty(in_empty),
		.join_afull(join_afull),
		.rd(rd),
		.vid_byte(vid_byte),
		.vid_class(vid_class),
		.vid_valid(vid_valid),
		.misc_byte(misc_byte),
		.misc_valid(misc_valid),
		.order_class(order_class),
		.order_valid(order_valid)
	);

	sign_scrambler scrambler_i (
		.clk(clk),
		.rst_n(rst_n),
		.vid_byte(vid_byte),
		.vid_class(vid_class),
		.vid_valid(vid_valid),
		.scr_byte(scr_byte),
		.scr_valid(scr_valid)
	);

	stream_joiner joiner_i (
		.clk(clk),
		.rst_n(rst_n),
		.scr_byte(scr_byte),
		.scr_valid(scr_valid),
		.misc_byte(misc_byte),
		.misc_valid(misc_valid),
		.order_class(order_class),
		.order_valid(order_valid),
		.join_afull(join_afull),
		.mpeg_out(mpeg_out),
		.mpeg_out_en(mpeg_out_en)
	);

	// source honours prog_full, so the input buffer never overruns
	assert property (@(posedge clk) disable iff (!rst_n)
		mpeg_in_en |-> in_count < IN_CW'(`BHG_IN_DEPTH));

endmodule

/* verilog/stream_joiner.sv */
`include "bhargava_settings.svh"

module stream_joiner (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [7:0]                   scr_byte,
	input  logic                         scr_valid,
	input  logic [7:0]                   misc_byte,
	input  logic                         misc_valid,
	input  mpeg_stream_pkg::byte_class_t order_class,
	input  logic                         order_valid,
	output logic                         join_afull,
	output logic [7:0]                   mpeg_out,
	output logic                         mpeg_out_en
);

	localparam int DEPTH = `BHG_JOIN_DEPTH;
	localparam int CW = $clog2(DEPTH + 1);

	scramble_pkg::join_state_t    state;
	mpeg_stream_pkg::byte_class_t head_class;

	logic [1:0]    order_dout;
	logic          order_empty;
	logic [CW-1:0] order_count;
	logic          order_rd;
	logic [7:0]    vid_dout;
	logic          vid_empty;
	logic [CW-1:0] vid_count;
	logic          vid_rd;
	logic [7:0]    misc_dout;
	logic          misc_empty;
	logic [CW-1:0] misc_count;
	logic          misc_rd;
	logic          head_is_vid;
	logic          emit;

	// order buffer drives the splitter stall
	byte_fifo #(.WIDTH(2), .DEPTH(DEPTH), .PROG_LEVEL(`BHG_JOIN_AFULL)) order_fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.din(order_class),
		.wr(order_valid),
		.rd(order_rd),
		.dout(order_dout),
		.empty(order_empty),
		.count(order_count),
		.prog_full(join_afull)
	);

	byte_fifo #(.WIDTH(8), .DEPTH(DEPTH), .PROG_LEVEL(DEPTH)) vid_fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.din(scr_byte),
		.wr(scr_valid),
		.rd(vid_rd),
		.dout(vid_dout),
		.empty(vid_empty),
		.count(vid_count),
		.prog_full()
	);

	byte_fifo #(.WIDTH(8), .DEPTH(DEPTH), .PROG_LEVEL(DEPTH)) misc_fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.din(misc_byte),
		.wr(misc_valid),
		.rd(misc_rd),
		.dout(misc_dout),
		.empty(misc_empty),
		.count(misc_count),
		.prog_full()
	);

	assign head_is_vid = (head_class != mpeg_stream_pkg::CLASS_MISC);
	assign vid_rd = (state == scramble_pkg::JOIN_EMIT) && head_is_vid && !vid_empty;
	assign misc_rd = (state == scramble_pkg::JOIN_EMIT) && !head_is_vid && !misc_empty;
	assign emit = vid_rd || misc_rd;
	// next head is popped alongside an emit to keep one byte per cycle
	assign order_rd = !order_empty && ((state == scramble_pkg::JOIN_IDLE) || emit);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= scramble_pkg::JOIN_IDLE;
			head_class <= mpeg_stream_pkg::CLASS_MISC;
			mpeg_out_en <= 1'b0;
		end else begin
			mpeg_out_en <= emit;
			if (order_rd) begin
				head_class <= mpeg_stream_pkg::byte_class_t'(order_dout);
				state <= scramble_pkg::JOIN_EMIT;
			end else if (emit) begin
				state <= scramble_pkg::JOIN_IDLE;
			end
		end
	end

	always_ff @(posedge clk) begin
		mpeg_out <= head_is_vid ? vid_dout : misc_dout;
	end

	// afull level must leave room for bytes still in the scrambler
	assert property (@(posedge clk) disable iff (!rst_n)
		!(order_valid && order_count == CW'(DEPTH)) &&
		!(scr_valid && vid_count == CW'(DEPTH)) &&
		!(misc_valid && misc_count == CW'(DEPTH)));

endmodule

/* verilog/sign_scrambler.sv */
`include "bhargava_settings.svh"

module sign_scrambler (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [7:0]                   vid_byte,
	input  mpeg_stream_pkg::byte_class_t vid_class,
	input  logic                         vid_valid,
	output logic [7:0]                   scr_byte,
	output logic                         scr_valid
);

	scramble_pkg::keystream_t     key;
	logic [7:0]                   s1_byte;
	mpeg_stream_pkg::byte_class_t s1_class;
	logic                         s1_key_bit;
	logic                         s1_valid;
	logic                         flip;

	// stage 1, sample key bit and step the lfsr
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			key <= `BHG_KEY_SEED;
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= vid_valid;
			if (vid_valid && vid_class == mpeg_stream_pkg::CLASS_VID_HDR)
				key <= `BHG_KEY_SEED;
			else if (vid_valid && vid_class == mpeg_stream_pkg::CLASS_VID_PAYLOAD)
				key <= {key[14:0], key[15] ^ key[13] ^ key[12] ^ key[10]};
		end
	end

	always_ff @(posedge clk) begin
		s1_byte <= vid_byte;
		s1_class <= vid_class;
		s1_key_bit <= key[15];
	end

	// headers pass untouched
	assign flip = s1_key_bit && (s1_class == mpeg_stream_pkg::CLASS_VID_PAYLOAD);

	always_ff @(posedge clk) begin
		if (!rst_n)
			scr_valid <= 1'b0;
		else
			scr_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		scr_byte <= {s1_byte[7] ^ flip, s1_byte[6:0]};
	end

	// misc bytes never reach the scrambler
	assert property (@(posedge clk) disable iff (!rst_n)
		vid_valid |-> (vid_class != mpeg_stream_pkg::CLASS_MISC));

endmodule

/* verilog/packet_splitter.sv */
`include "bhargava_settings.svh"

module packet_splitter (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [7:0]                  dout,
	input  logic                        empty,
	input  logic                        join_afull,
	output logic                        rd,
	output logic [7:0]                  vid_byte,
	output mpeg_stream_pkg::byte_class_t vid_class,
	output logic                        vid_valid,
	output logic [7:0]                  misc_byte,
	output logic                        misc_valid,
	output mpeg_stream_pkg::byte_class_t order_class,
	output logic                        order_valid
);

	localparam int PKT_LEN = `BHG_PKT_LEN;
	localparam int POS_W = (PKT_LEN > 1) ? $clog2(PKT_LEN) : 1;

	mpeg_stream_pkg::split_state_t state;
	mpeg_stream_pkg::byte_class_t  cls;
	logic [POS_W-1:0]              pos;
	logic                          last_byte;

	// head byte is consumed in the cycle it is read
	assign rd = !empty && !join_afull;
	assign last_byte = (pos == POS_W'(PKT_LEN - 1));

	always_comb begin
		case (state)
			mpeg_stream_pkg::SPLIT_VIDEO: cls = mpeg_stream_pkg::CLASS_VID_PAYLOAD;
			mpeg_stream_pkg::SPLIT_MISC:  cls = mpeg_stream_pkg::CLASS_MISC;
			default:
				cls = (dout == `BHG_VIDEO_ID) ? mpeg_stream_pkg::CLASS_VID_HDR :
					mpeg_stream_pkg::CLASS_MISC;
		endcase
	end

	assign vid_byte = dout;
	assign vid_class = cls;
	assign vid_valid = rd && (cls != mpeg_stream_pkg::CLASS_MISC);
	assign misc_byte = dout;
	assign misc_valid = rd && (cls == mpeg_stream_pkg::CLASS_MISC);
	assign order_class = cls;
	assign order_valid = rd;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= mpeg_stream_pkg::SPLIT_HEADER;
			pos <= '0;
		end else if (rd) begin
			if (last_byte) begin
				pos <= '0;
				state <= mpeg_stream_pkg::SPLIT_HEADER;
			end else begin
				pos <= pos + 1'b1;
				if (state == mpeg_stream_pkg::SPLIT_HEADER)
					state <= (cls == mpeg_stream_pkg::CLASS_VID_HDR) ?
						mpeg_stream_pkg::SPLIT_VIDEO : mpeg_stream_pkg::SPLIT_MISC;
			end
		end
	end

	// header state only at the start of a packet
	assert property (@(posedge clk) disable iff (!rst_n)
		(pos == '0) == (state == mpeg_stream_pkg::SPLIT_HEADER));

endmodule

/* verilog/byte_fifo.sv */
module byte_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16,
	parameter int PROG_LEVEL = 12
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [WIDTH-1:0]           din,
	input  logic                       wr,
	input  logic                       rd,
	output logic [WIDTH-1:0]           dout,
	output logic                       empty,
	output logic [$clog2(DEPTH+1)-1:0] count,
	output logic                       prog_full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    count_next;

	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	assign count_next = count + CW'(wr) - CW'(rd);

	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			prog_full <= 1'b0;
		end else begin
			if (wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count_next;
			// flag follows the new fill level, no extra lag
			prog_full <= (count_next >= CW'(PROG_LEVEL));
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		wr |-> (count < CW'(DEPTH)) || rd);

	assert property (@(posedge clk) disable iff (!rst_n)
		rd |-> !empty);

endmodule

/* verilog/scramble_pkg.sv */
package scramble_pkg;

	// lfsr state, bit 15 is the keystream bit
	typedef logic [15:0] keystream_t;

	typedef enum logic {
		JOIN_IDLE = 1'b0,
		JOIN_EMIT = 1'b1
	} join_state_t;

endpackage

/* verilog/mpeg_stream_pkg.sv */
package mpeg_stream_pkg;

	// class of each byte, carried with it to the scrambler and joiner
	typedef enum logic [1:0] {
		CLASS_VID_HDR     = 2'd0,
		CLASS_VID_PAYLOAD = 2'd1,
		CLASS_MISC        = 2'd2
	} byte_class_t;

	// where the splitter is within a packet
	typedef enum logic [1:0] {
		SPLIT_HEADER = 2'd0,
		SPLIT_VIDEO  = 2'd1,
		SPLIT_MISC   = 2'd2
	} split_state_t;

endpackage

/* include/bhargava_settings.svh */
`ifndef BHARGAVA_SETTINGS_SVH
`define BHARGAVA_SETTINGS_SVH

// bytes per packet, header byte included
`define BHG_PKT_LEN 8

// header value of a video packet
`define BHG_VIDEO_ID 8'hE0

// input buffer
`define BHG_IN_DEPTH 16
`define BHG_IN_PROG_FULL 12

// joiner buffers, splitter stalls at the afull level
`define BHG_JOIN_DEPTH 8
`define BHG_JOIN_AFULL 5

`define BHG_KEY_SEED 16'hACE1

`endif
